//--- src/intOpPkg.sv
package intOpPkg;

    // Operand and result width, fixed by RV32I semantics
    localparam int dataWidth = 32;

    // Shift amounts come from the low bits of operand 1
    localparam int shamtWidth = 5;

    typedef logic [dataWidth-1:0] dataWord;

    // Return address step for jal and jalr
    localparam dataWord linkOffset = dataWord'(4);

    typedef enum logic [4:0] {
        // ALU group
        intAdd,
        intAuipc,
        intSub,
        intXor,
        intOr,
        intAnd,
        intSll,
        intSrl,
        intSra,
        intSlt,
        intSltu,
        intLui,
        // Conditional branches
        intBeq,
        intBne,
        intBlt,
        intBge,
        intBltu,
        intBgeu,
        // Unconditional jumps
        intJal,
        intJalr
    } intOpcode;

endpackage

//--- src/uopPkg.sv
package uopPkg;

    // Physical register tag width unless the top level overrides it
    localparam int defTagWidth = 6;

    // Architectural register number, x0 to x31
    localparam int regNumWidth = 5;

    // Sequence number width unless the top level overrides it
    localparam int defSqnWidth = 6;

    // Registered writeback record state
    typedef enum logic [1:0] {
        // No record this cycle
        idle = 2'b00,
        // Record valid, no redirect
        resultOnly = 2'b01,
        // Record valid and carries a taken branch
        resolvedTaken = 2'b11
    } wbState;

endpackage

//--- src/intIssueIf.sv
`timescale 1ns/1ps

interface intIssueIf #(
    parameter int tagWidth = uopPkg::defTagWidth,
    parameter int sqnWidth = uopPkg::defSqnWidth
);

    logic valid;

    // Operand 2 holds the branch offset or target
    intOpPkg::dataWord operand0;
    intOpPkg::dataWord operand1;
    intOpPkg::dataWord operand2;
    intOpPkg::intOpcode opcode;

    // Destination and ordering bookkeeping
    logic [tagWidth-1:0] tagDst;
    logic [uopPkg::regNumWidth-1:0] nmDst;
    logic [sqnWidth-1:0] sqN;

    modport source (
        output valid,
        output operand0,
        output operand1,
        output operand2,
        output opcode,
        output tagDst,
        output nmDst,
        output sqN
    );

    modport alu (
        input operand0,
        input operand1,
        input opcode
    );

    modport branch (
        input operand0,
        input operand1,
        input operand2,
        input opcode
    );

    modport wb (
        input valid,
        input opcode,
        input tagDst,
        input nmDst,
        input sqN
    );

endinterface

//--- src/intResultUnit.sv
`timescale 1ns/1ps

module intResultUnit (
    intIssueIf.alu issue,
    output intOpPkg::dataWord result
);

    logic [intOpPkg::shamtWidth-1:0] shamt;
    logic lessSigned;
    logic lessUnsigned;

    // Upper bits of operand 1 are ignored for shifts
    assign shamt = issue.operand1[intOpPkg::shamtWidth-1:0];

    assign lessSigned = $signed(issue.operand0) < $signed(issue.operand1);
    assign lessUnsigned = issue.operand0 < issue.operand1;

    always_comb begin
        case (issue.opcode)
            // auipc gets the PC in operand 0 and the upper immediate in operand 1
            intOpPkg::intAdd,
            intOpPkg::intAuipc: begin
                result = issue.operand0 + issue.operand1;
            end
            intOpPkg::intSub: begin
                result = issue.operand0 - issue.operand1;
            end
            intOpPkg::intXor: begin
                result = issue.operand0 ^ issue.operand1;
            end
            intOpPkg::intOr: begin
                result = issue.operand0 | issue.operand1;
            end
            intOpPkg::intAnd: begin
                result = issue.operand0 & issue.operand1;
            end
            intOpPkg::intSll: begin
                result = issue.operand0 << shamt;
            end
            intOpPkg::intSrl: begin
                result = issue.operand0 >> shamt;
            end
            intOpPkg::intSra: begin
                result = $signed(issue.operand0) >>> shamt;
            end
            intOpPkg::intSlt: begin
                result = intOpPkg::dataWord'(lessSigned);
            end
            intOpPkg::intSltu: begin
                result = intOpPkg::dataWord'(lessUnsigned);
            end
            intOpPkg::intLui: begin
                result = issue.operand1;
            end
            // Link value, operand 0 is the PC of the jump
            intOpPkg::intJal,
            intOpPkg::intJalr: begin
                result = issue.operand0 + intOpPkg::linkOffset;
            end
            // Conditional branches never write a destination
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- src/branchResolver.sv
`timescale 1ns/1ps

module branchResolver (
    intIssueIf.branch issue,
    output logic isBranch,
    output logic taken,
    output intOpPkg::dataWord target
);

    logic equal;
    logic lessSigned;
    logic lessUnsigned;

    // Shared comparators for all conditional branches
    assign equal = issue.operand0 == issue.operand1;
    assign lessSigned = $signed(issue.operand0) < $signed(issue.operand1);
    assign lessUnsigned = issue.operand0 < issue.operand1;

    // Branch and jump group classification
    always_comb begin
        case (issue.opcode)
            intOpPkg::intBeq,
            intOpPkg::intBne,
            intOpPkg::intBlt,
            intOpPkg::intBge,
            intOpPkg::intBltu,
            intOpPkg::intBgeu,
            intOpPkg::intJal,
            intOpPkg::intJalr: begin
                isBranch = 1'b1;
            end
            default: begin
                isBranch = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (issue.opcode)
            // Jumps always redirect
            intOpPkg::intJal,
            intOpPkg::intJalr: begin
                taken = 1'b1;
            end
            intOpPkg::intBeq: begin
                taken = equal;
            end
            intOpPkg::intBne: begin
                taken = !equal;
            end
            intOpPkg::intBlt: begin
                taken = lessSigned;
            end
            intOpPkg::intBge: begin
                taken = !lessSigned;
            end
            intOpPkg::intBltu: begin
                taken = lessUnsigned;
            end
            intOpPkg::intBgeu: begin
                taken = !lessUnsigned;
            end
            // Plain ALU ops never redirect
            default: begin
                taken = 1'b0;
            end
        endcase
    end

    // Targets arrive precomputed in operand 2 except for the register relative jalr
    always_comb begin
        if (issue.opcode == intOpPkg::intJalr) begin
            target = issue.operand1 + issue.operand2;
        end else begin
            target = issue.operand2;
        end
    end

    always_comb begin
        takenIsBranch: assert (!taken || isBranch)
            else $error("branchResolver: taken raised for a non-branch opcode");
    end

endmodule

//--- src/intWriteback.sv
`timescale 1ns/1ps

module intWriteback #(
    parameter int tagWidth = uopPkg::defTagWidth,
    parameter int sqnWidth = uopPkg::defSqnWidth
) (
    input  logic clk,
    input  logic rstN,
    intIssueIf.wb issue,
    input  logic wbStall,
    input  intOpPkg::dataWord result,
    input  logic isBranch,
    input  logic taken,
    input  intOpPkg::dataWord target,
    output logic outValid,
    output logic outIsBranch,
    output logic branchTaken,
    output intOpPkg::dataWord branchAddress,
    output logic [sqnWidth-1:0] branchSqN,
    output intOpPkg::dataWord outResult,
    output logic [tagWidth-1:0] outTagDst,
    output logic [uopPkg::regNumWidth-1:0] outNmDst,
    output logic [sqnWidth-1:0] outSqN
);

    uopPkg::wbState state;
    uopPkg::wbState stateNext;
    logic signed [sqnWidth-1:0] sqnDelta;
    logic squash;
    logic accept;

    // Wrap-around distance to the resolved branch, positive means younger
    assign sqnDelta = issue.sqN - branchSqN;

    // Only ops strictly younger than a just-taken branch are dropped
    assign squash = branchTaken && (sqnDelta > 0);

    assign accept = issue.valid && !wbStall && !squash;

    always_comb begin
        if (!accept) begin
            stateNext = uopPkg::idle;
        end else if (taken) begin
            stateNext = uopPkg::resolvedTaken;
        end else begin
            stateNext = uopPkg::resultOnly;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= uopPkg::idle;
        end else begin
            state <= stateNext;
        end
    end

    // Record fields load with each accepted op
    always_ff @(posedge clk) begin
        if (accept) begin
            outIsBranch <= isBranch;
            branchAddress <= target;
            branchSqN <= issue.sqN;
            outResult <= result;
            outTagDst <= issue.tagDst;
            outNmDst <= issue.nmDst;
            outSqN <= issue.sqN;
        end
    end

    // Valid and taken flags decode from the record state
    assign outValid = state != uopPkg::idle;
    assign branchTaken = state == uopPkg::resolvedTaken;

    takenHasBranchRecord: assert property (
        @(posedge clk) disable iff (!rstN)
        branchTaken |-> outValid && outIsBranch
    ) else $error("intWriteback: branchTaken without a valid branch record");

    stallBlocksOutput: assert property (
        @(posedge clk) disable iff (!rstN)
        issue.valid && wbStall |=> !outValid
    ) else $error("intWriteback: record emitted after a stalled cycle");

    // An accepted jump must come back as a taken redirect
    jumpAlwaysTaken: assert property (
        @(posedge clk) disable iff (!rstN)
        accept && (issue.opcode == intOpPkg::intJal || issue.opcode == intOpPkg::intJalr)
            |=> branchTaken
    ) else $error("intWriteback: accepted jump did not resolve as taken");

endmodule

//--- src/intExecUnit.sv
`timescale 1ns/1ps

module intExecUnit #(
    parameter int tagWidth = uopPkg::defTagWidth,
    parameter int sqnWidth = uopPkg::defSqnWidth
) (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    input  logic wbStall,
    input  intOpPkg::dataWord operand0,
    input  intOpPkg::dataWord operand1,
    input  intOpPkg::dataWord operand2,
    input  intOpPkg::intOpcode opcode,
    input  logic [tagWidth-1:0] tagDst,
    input  logic [uopPkg::regNumWidth-1:0] nmDst,
    input  logic [sqnWidth-1:0] sqN,
    output logic wbReq,
    output logic outValid,
    output logic outIsBranch,
    output logic branchTaken,
    output intOpPkg::dataWord branchAddress,
    output logic [sqnWidth-1:0] branchSqN,
    output intOpPkg::dataWord outResult,
    output logic [tagWidth-1:0] outTagDst,
    output logic [uopPkg::regNumWidth-1:0] outNmDst,
    output logic [sqnWidth-1:0] outSqN
);

    intOpPkg::dataWord result;
    intOpPkg::dataWord target;
    logic isBranch;
    logic taken;

    intIssueIf #(
        .tagWidth(tagWidth),
        .sqnWidth(sqnWidth)
    ) issue ();

    // Issued micro-op onto the internal bundle
    assign issue.valid = inValid;
    assign issue.operand0 = operand0;
    assign issue.operand1 = operand1;
    assign issue.operand2 = operand2;
    assign issue.opcode = opcode;
    assign issue.tagDst = tagDst;
    assign issue.nmDst = nmDst;
    assign issue.sqN = sqN;

    // Writeback slot request, answered by wbStall in the same cycle
    assign wbReq = inValid;

    intResultUnit resultUnit (
        .issue(issue.alu),
        .result(result)
    );

    branchResolver resolver (
        .issue(issue.branch),
        .isBranch(isBranch),
        .taken(taken),
        .target(target)
    );

    intWriteback #(
        .tagWidth(tagWidth),
        .sqnWidth(sqnWidth)
    ) writeback (
        .clk(clk),
        .rstN(rstN),
        .issue(issue.wb),
        .wbStall(wbStall),
        .result(result),
        .isBranch(isBranch),
        .taken(taken),
        .target(target),
        .outValid(outValid),
        .outIsBranch(outIsBranch),
        .branchTaken(branchTaken),
        .branchAddress(branchAddress),
        .branchSqN(branchSqN),
        .outResult(outResult),
        .outTagDst(outTagDst),
        .outNmDst(outNmDst),
        .outSqN(outSqN)
    );

endmodule

//--- testbench/tbIntExec.sv
`timescale 1ns/1ps

module tbIntExec;

    localparam int tagW = uopPkg::defTagWidth;
    localparam int sqnW = uopPkg::defSqnWidth;
    localparam int nmW = uopPkg::regNumWidth;
    localparam int watchdogCycles = 5000;
    localparam int drainLimit = 20;

    // One micro-op as it was accepted by the writeback handshake
    typedef struct packed {
        intOpPkg::intOpcode op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [tagW-1:0] tag;
        logic [nmW-1:0] nm;
        logic [sqnW-1:0] sqn;
    } uopRec;

    typedef struct packed {
        logic [31:0] result;
        logic isBranch;
        logic taken;
        logic [31:0] target;
    } expectRec;

    logic clk;
    logic rstN;
    logic inValid;
    logic wbStall;
    intOpPkg::dataWord operand0;
    intOpPkg::dataWord operand1;
    intOpPkg::dataWord operand2;
    intOpPkg::intOpcode opcode;
    logic [tagW-1:0] tagDst;
    logic [nmW-1:0] nmDst;
    logic [sqnW-1:0] sqN;
    logic wbReq;
    logic outValid;
    logic outIsBranch;
    logic branchTaken;
    intOpPkg::dataWord branchAddress;
    logic [sqnW-1:0] branchSqN;
    intOpPkg::dataWord outResult;
    logic [tagW-1:0] outTagDst;
    logic [nmW-1:0] outNmDst;
    logic [sqnW-1:0] outSqN;

    logic [31:0] seed = 32'h6c9c99ab;
    logic [sqnW-1:0] seqCount = '0;
    uopRec pendQ[$];
    string nameQ[$];
    string phaseName = "reset";
    int errorCount = 0;
    int checkCount = 0;
    int squashCount = 0;
    logic lastTaken = 1'b0;
    logic [sqnW-1:0] lastSqN = '0;

    intExecUnit DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic isYounger(input logic [sqnW-1:0] sqn,
                                       input logic [sqnW-1:0] branchSeq);
        logic [sqnW-1:0] diff;
        // Ahead by less than half the number space means younger
        diff = sqn - branchSeq;
        return (diff != '0) && !diff[sqnW-1];
    endfunction

    function automatic expectRec refModel(input uopRec u);
        expectRec e;
        logic [intOpPkg::shamtWidth-1:0] sh;
        logic uLess;
        logic sLess;
        sh = u.b[intOpPkg::shamtWidth-1:0];
        uLess = u.a < u.b;
        // With different signs the negative operand is the smaller one
        sLess = (u.a[31] != u.b[31]) ? u.a[31] : uLess;
        e.result = '0;
        e.taken = 1'b0;
        e.target = u.c;
        case (u.op)
            intOpPkg::intAdd, intOpPkg::intAuipc: e.result = u.a + u.b;
            intOpPkg::intSub: e.result = u.a - u.b;
            intOpPkg::intXor: e.result = u.a ^ u.b;
            intOpPkg::intOr: e.result = u.a | u.b;
            intOpPkg::intAnd: e.result = u.a & u.b;
            intOpPkg::intSll: e.result = u.a << sh;
            intOpPkg::intSrl: e.result = u.a >> sh;
            // Logical shift, vacated top bits refilled from the sign
            intOpPkg::intSra: e.result = (u.a >> sh) | ({32{u.a[31]}} & ~(32'hffffffff >> sh));
            intOpPkg::intSlt: e.result = {31'b0, sLess};
            intOpPkg::intSltu: e.result = {31'b0, uLess};
            intOpPkg::intLui: e.result = u.b;
            intOpPkg::intBeq: e.taken = u.a == u.b;
            intOpPkg::intBne: e.taken = u.a != u.b;
            intOpPkg::intBlt: e.taken = sLess;
            intOpPkg::intBge: e.taken = !sLess;
            intOpPkg::intBltu: e.taken = uLess;
            intOpPkg::intBgeu: e.taken = !uLess;
            intOpPkg::intJal: begin
                e.result = u.a + 32'd4;
                e.taken = 1'b1;
            end
            intOpPkg::intJalr: begin
                e.result = u.a + 32'd4;
                e.taken = 1'b1;
                e.target = u.b + u.c;
            end
            default: ;
        endcase
        e.isBranch = u.op inside {intOpPkg::intBeq, intOpPkg::intBne, intOpPkg::intBlt,
            intOpPkg::intBge, intOpPkg::intBltu, intOpPkg::intBgeu, intOpPkg::intJal,
            intOpPkg::intJalr};
        return e;
    endfunction

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        valueCheck: assert (actual === expected)
            else begin
                errorCount++;
                $display("Fail %s: %s expected %h, actual %h", testName, field, expected, actual);
            end
    endtask

    task automatic finishRun();
        $display("Checks: %0d, errors: %0d, squashed ops: %0d",
                 checkCount, errorCount, squashCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // Presents one op and holds it through the stall cycles until the slot is granted
    task automatic issueOp(input string name, input intOpPkg::intOpcode op,
                           input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                           input int stallCycles, input logic [sqnW-1:0] sqn);
        uopRec u;
        int stallLeft;
        u.op = op;
        u.a = a;
        u.b = b;
        u.c = c;
        u.tag = tagW'(nextRand());
        u.nm = nmW'(nextRand());
        u.sqn = sqn;
        stallLeft = stallCycles;
        phaseName = name;
        #1;
        inValid = 1'b1;
        operand0 = a;
        operand1 = b;
        operand2 = c;
        opcode = op;
        tagDst = u.tag;
        nmDst = u.nm;
        sqN = sqn;
        wbStall = stallLeft > 0;
        #1;
        checkValue(name, "wbReq", 32'd1, 32'(wbReq));
        @(posedge clk);
        while (stallLeft > 0) begin
            stallLeft--;
            #1;
            wbStall = stallLeft > 0;
            @(posedge clk);
        end
        pendQ.push_back(u);
        nameQ.push_back(name);
    endtask

    task automatic issueNext(input string name, input intOpPkg::intOpcode op,
                             input logic [31:0] a, input logic [31:0] b, input logic [31:0] c,
                             input int stallCycles);
        issueOp(name, op, a, b, c, stallCycles, seqCount);
        seqCount++;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            #1;
            inValid = 1'b0;
            wbStall = 1'b0;
            #1;
            checkValue(phaseName, "wbReq", 32'd0, 32'(wbReq));
            @(posedge clk);
        end
    endtask

    // One record expected per accepted op, in the cycle after its accept edge
    task automatic compareCycle();
        uopRec u;
        expectRec e;
        string name;
        if (pendQ.size() == 0) begin
            checkValue(phaseName, "outValid", 32'd0, 32'(outValid));
            checkValue(phaseName, "branchTaken", 32'd0, 32'(branchTaken));
            lastTaken = 1'b0;
        end else begin
            u = pendQ.pop_front();
            name = nameQ.pop_front();
            e = refModel(u);
            if (lastTaken && isYounger(u.sqn, lastSqN)) begin
                squashCount++;
                checkValue(name, "outValid after squash", 32'd0, 32'(outValid));
                checkValue(name, "branchTaken after squash", 32'd0, 32'(branchTaken));
                lastTaken = 1'b0;
            end else begin
                checkValue(name, "outValid", 32'd1, 32'(outValid));
                checkValue(name, "outResult", e.result, outResult);
                checkValue(name, "outTagDst", 32'(u.tag), 32'(outTagDst));
                checkValue(name, "outNmDst", 32'(u.nm), 32'(outNmDst));
                checkValue(name, "outSqN", 32'(u.sqn), 32'(outSqN));
                checkValue(name, "outIsBranch", 32'(e.isBranch), 32'(outIsBranch));
                checkValue(name, "branchTaken", 32'(e.taken), 32'(branchTaken));
                if (e.taken) begin
                    checkValue(name, "branchAddress", e.target, branchAddress);
                    checkValue(name, "branchSqN", 32'(u.sqn), 32'(branchSqN));
                end
                lastTaken = e.taken;
                lastSqN = u.sqn;
            end
        end
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (pendQ.size() != 0 && cycles < drainLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (pendQ.size() != 0) begin
            errorCount++;
            $display("Timeout: %0d expected records never appeared", pendQ.size());
        end
    endtask

    always @(negedge clk) begin
        if (rstN) begin
            compareCycle();
        end
    end

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge clk);
        errorCount++;
        $display("Timeout: the run did not complete within %0d cycles", watchdogCycles);
        finishRun();
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] c;
        intOpPkg::intOpcode op;
        rstN = 1'b0;
        inValid = 1'b0;
        wbStall = 1'b0;
        operand0 = '0;
        operand1 = '0;
        operand2 = '0;
        opcode = intOpPkg::intAdd;
        tagDst = '0;
        nmDst = '0;
        sqN = '0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkValue("reset", "outValid", 32'd0, 32'(outValid));
        checkValue("reset", "branchTaken", 32'd0, 32'(branchTaken));
        @(posedge clk);

        // ALU group with random operands, then sign and shift edge values
        for (int k = int'(intOpPkg::intAdd); k <= int'(intOpPkg::intLui); k++) begin
            op = intOpPkg::intOpcode'(k);
            for (int n = 0; n < 3; n++) begin
                issueNext("aluRandom", op, nextRand(), nextRand(), nextRand(), 0);
            end
            issueNext("aluEdge", op, 32'h80000000, 32'h7fffffff, '0, 0);
            issueNext("aluEdge", op, 32'hfffffff0, 32'hffffffe3, '0, 0);
        end

        // Idle after each branch so the next op is never squashed
        for (int k = int'(intOpPkg::intBeq); k <= int'(intOpPkg::intBgeu); k++) begin
            op = intOpPkg::intOpcode'(k);
            a = nextRand();
            c = nextRand();
            issueNext("branchEqual", op, a, a, c, 0);
            idleCycles(1);
            issueNext("branchSignedLess", op, 32'hfffffff0, 32'h00000010, c, 0);
            idleCycles(1);
            issueNext("branchUnsignedLess", op, 32'h00000005, 32'h80000000, c, 0);
            idleCycles(1);
        end

        for (int n = 0; n < 3; n++) begin
            issueNext("jal", intOpPkg::intJal, nextRand(), nextRand(), nextRand(), 0);
            idleCycles(1);
            issueNext("jalr", intOpPkg::intJalr, nextRand(), nextRand(), nextRand(), 0);
            idleCycles(1);
        end

        issueNext("stallAlu", intOpPkg::intSub, nextRand(), nextRand(), '0, 2);
        issueNext("stallJump", intOpPkg::intJalr, nextRand(), nextRand(), nextRand(), 3);
        idleCycles(2);

        // Taken branch followed directly by an op with a chosen sequence number
        issueOp("squashYounger", intOpPkg::intBeq, 32'h1234, 32'h1234, 32'h400, 0, 6'd10);
        issueOp("squashYounger", intOpPkg::intAdd, nextRand(), nextRand(), '0, 0, 6'd11);
        idleCycles(1);
        issueOp("keepOlder", intOpPkg::intBeq, 32'd7, 32'd7, 32'h800, 0, 6'd20);
        issueOp("keepOlder", intOpPkg::intXor, nextRand(), nextRand(), '0, 0, 6'd19);
        idleCycles(1);
        issueOp("squashWrap", intOpPkg::intJal, nextRand(), '0, 32'h900, 0, 6'd63);
        issueOp("squashWrap", intOpPkg::intOr, nextRand(), nextRand(), '0, 0, 6'd0);
        idleCycles(1);
        issueOp("keepOlderWrap", intOpPkg::intJal, nextRand(), '0, 32'ha00, 0, 6'd1);
        issueOp("keepOlderWrap", intOpPkg::intAnd, nextRand(), nextRand(), '0, 0, 6'd62);
        idleCycles(1);
        issueOp("keepNotTaken", intOpPkg::intBne, 32'd3, 32'd3, 32'hb00, 0, 6'd30);
        issueOp("keepNotTaken", intOpPkg::intSll, nextRand(), nextRand(), '0, 0, 6'd31);
        idleCycles(2);

        waitDrain();
        finishRun();
    end

endmodule

//--- project.f
src/intOpPkg.sv
src/uopPkg.sv
src/intIssueIf.sv
src/intResultUnit.sv
src/branchResolver.sv
src/intWriteback.sv
src/intExecUnit.sv
testbench/tbIntExec.sv

//--- run.sh
#!/bin/sh
# Compile and run the integer execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=simIntExec
logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tbIntExec -Mdir "$buildDir" -o "$simName"
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

# The testbench prints its fail line on any check error or timeout
if grep -q "ERRORS FOUND" "$logFile"; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0
